// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // defaults for the top parameters, the typedefs below are sized from these
    localparam int DATA_W  = 16;
    localparam int ADDR_W  = 6;
    localparam int FIELD_W = 3;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [FIELD_W-1:0] field_addr_t;

    // opcode values not listed here execute as no-ops
    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef struct packed {
        logic        ind;   // set: the addressed word is a pointer
        field_addr_t addr;
    } operand_t;

    typedef struct packed {
        opcode_e  opcode;
        operand_t a;
        operand_t b;
        operand_t c;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_e;

    typedef enum logic [4:0] {
        S_INIT,
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_IMM,
        S_IMM_WAIT,
        S_RD_A,
        S_RD_A_WAIT,
        S_RD_A_PTR,
        S_RD_A_PTR_WAIT,
        S_RD_B,
        S_RD_B_WAIT,
        S_RD_B_PTR,
        S_RD_B_PTR_WAIT,
        S_RD_C,
        S_RD_C_WAIT,
        S_RD_C_PTR,
        S_RD_C_PTR_WAIT,
        S_EXEC,
        S_WR_A_PTR,         // fetch the pointer word of an indirect destination
        S_WR_A_PTR_WAIT,
        S_WR_A,
        S_WR_A_WAIT,
        S_OUT,
        S_HALT
    } state_e;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } mem_cmd_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat_r;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        AS_PC,
        AS_FIELD_A,
        AS_FIELD_B,
        AS_FIELD_C,
        AS_POINTER
    } addr_sel_e;

    typedef enum logic [1:0] {
        WD_IN,
        WD_OPB,
        WD_IMM,
        WD_RESULT
    } wdata_sel_e;

    typedef struct packed {
        logic       pc_init;
        logic       pc_inc;
        logic       ir_ld;
        logic       imm_ld;
        logic       opb_ld;
        logic       opc_ld;
        logic       opa_ld;
        logic       res_ld;
        logic       out_ld;
        logic       mem_we;     // write flag of the command being issued
        alu_op_e    alu_op;
        addr_sel_e  addr_sel;
        wdata_sel_e wdata_sel;
    } dp_ctrl_t;

endpackage

// ==== hdl/cpu_bus_master.sv ====
`timescale 1ns/1ps

module cpu_bus_master #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  cpu_pkg::mem_cmd_t  cmd,
    output logic               cmd_done,
    output cpu_pkg::data_t     rd_data,
    output cpu_pkg::wb_req_t   wb_req,
    input  cpu_pkg::wb_rsp_t   wb_rsp
);

    logic                  cyc_q;     // also the busy flag, one transfer at a time
    logic                  we_q;
    logic                  done_q;
    logic [ADDR_WIDTH-1:0] adr_q;
    logic [DATA_WIDTH-1:0] dat_w_q;
    logic [DATA_WIDTH-1:0] dat_r_q;
    logic                  start;
    logic                  finish;

    assign start  = !cyc_q && cmd_valid;
    assign finish = cyc_q && wb_rsp.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= finish;     // cmd_done trails the ack by one cycle
            if (finish) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end else if (start) begin
                cyc_q <= 1'b1;
                we_q  <= cmd.we;
            end
        end
    end

    // address and data are held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q   <= cmd.addr;
            dat_w_q <= cmd.data;
        end
        // keep the last read word, writes leave it alone
        if (finish && !we_q) begin
            dat_r_q <= wb_rsp.dat_r;
        end
    end

    always_comb begin
        wb_req.cyc   = cyc_q;
        wb_req.stb   = cyc_q;
        wb_req.we    = we_q;
        wb_req.adr   = adr_q;
        wb_req.dat_w = dat_w_q;
    end

    assign cmd_done = done_q;
    assign rd_data  = dat_r_q;

endmodule

// ==== hdl/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16,
    parameter int START_PC   = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::dp_ctrl_t  ctrl,
    input  cpu_pkg::data_t     rd_data,
    input  cpu_pkg::data_t     in_data,
    output cpu_pkg::instr_t    instr,
    output cpu_pkg::mem_cmd_t  mem_cmd,
    output cpu_pkg::data_t     out_data,
    output logic               out_valid
);

    cpu_pkg::addr_t  pc;
    cpu_pkg::instr_t ir;
    cpu_pkg::data_t  imm;
    cpu_pkg::data_t  opa;
    cpu_pkg::data_t  opb;
    cpu_pkg::data_t  opc;
    cpu_pkg::data_t  result;
    cpu_pkg::data_t  out_q;
    logic            out_valid_q;

    logic [2*DATA_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0]   alu_y;
    logic [ADDR_WIDTH-1:0]   pointer;   // low bits of the pointer word just read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            out_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (ctrl.pc_init) begin
                pc <= cpu_pkg::addr_t'(START_PC);
            end else if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.out_ld) begin
                out_q <= opa;
            end
            out_valid_q <= ctrl.out_ld;   // pulse lines up with the new out_q
        end
    end

    // instruction, immediate and operands all come from the bus read data
    always_ff @(posedge clk) begin
        if (ctrl.ir_ld) begin
            ir <= cpu_pkg::instr_t'(rd_data);
        end
        if (ctrl.imm_ld) begin
            imm <= rd_data;
        end
        if (ctrl.opa_ld) begin
            opa <= rd_data;
        end
        if (ctrl.opb_ld) begin
            opb <= rd_data;
        end
        if (ctrl.opc_ld) begin
            opc <= rd_data;
        end
        if (ctrl.res_ld) begin
            result <= alu_y;
        end
    end

    // alu, results wrap modulo 2^DATA_WIDTH
    always_comb begin
        product = opb * opc;
        case (ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_y = opb + opc;
            cpu_pkg::ALU_SUB: alu_y = opb - opc;
            cpu_pkg::ALU_MUL: alu_y = product[DATA_WIDTH-1:0];  // low half only
            default:          alu_y = opb + opc;
        endcase
    end

    assign pointer = rd_data[ADDR_WIDTH-1:0];

    always_comb begin
        mem_cmd.we = ctrl.mem_we;
        case (ctrl.addr_sel)
            cpu_pkg::AS_PC:      mem_cmd.addr = pc;
            cpu_pkg::AS_FIELD_A: mem_cmd.addr = cpu_pkg::addr_t'(ir.a.addr);
            cpu_pkg::AS_FIELD_B: mem_cmd.addr = cpu_pkg::addr_t'(ir.b.addr);
            cpu_pkg::AS_FIELD_C: mem_cmd.addr = cpu_pkg::addr_t'(ir.c.addr);
            cpu_pkg::AS_POINTER: mem_cmd.addr = pointer;
            default:             mem_cmd.addr = pc;
        endcase
        case (ctrl.wdata_sel)
            cpu_pkg::WD_IN:     mem_cmd.data = in_data;
            cpu_pkg::WD_OPB:    mem_cmd.data = opb;
            cpu_pkg::WD_IMM:    mem_cmd.data = imm;
            cpu_pkg::WD_RESULT: mem_cmd.data = result;
            default:            mem_cmd.data = result;
        endcase
    end

    assign instr     = ir;
    assign out_data  = out_q;
    assign out_valid = out_valid_q;

endmodule

// ==== hdl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::instr_t    instr,
    input  logic               cmd_done,
    output logic               cmd_valid,
    output cpu_pkg::dp_ctrl_t  ctrl,
    output logic               halted
);

    cpu_pkg::state_e state;
    cpu_pkg::state_e state_n;
    cpu_pkg::state_e wr_entry;    // first state of the write-back of a
    cpu_pkg::state_e after_b;

    assign wr_entry = instr.a.ind ? cpu_pkg::S_WR_A_PTR : cpu_pkg::S_WR_A;
    assign after_b  = (instr.opcode == cpu_pkg::OP_MOV) ? wr_entry : cpu_pkg::S_RD_C;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::S_INIT;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n   = state;
        cmd_valid = 1'b0;
        ctrl      = '0;

        // operation selects follow the opcode, only the load strobes are per state
        case (instr.opcode)
            cpu_pkg::OP_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_MUL: ctrl.alu_op = cpu_pkg::ALU_MUL;
            default:         ctrl.alu_op = cpu_pkg::ALU_ADD;
        endcase
        case (instr.opcode)
            cpu_pkg::OP_IN:  ctrl.wdata_sel = cpu_pkg::WD_IN;
            cpu_pkg::OP_MOV: ctrl.wdata_sel = instr.c.ind ? cpu_pkg::WD_IMM : cpu_pkg::WD_OPB;
            default:         ctrl.wdata_sel = cpu_pkg::WD_RESULT;
        endcase

        case (state)
            cpu_pkg::S_INIT: begin
                ctrl.pc_init = 1'b1;
                state_n      = cpu_pkg::S_FETCH;
            end
            cpu_pkg::S_FETCH, cpu_pkg::S_IMM: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_PC;
                ctrl.pc_inc   = 1'b1;
                state_n = (state == cpu_pkg::S_FETCH) ? cpu_pkg::S_FETCH_WAIT
                                                      : cpu_pkg::S_IMM_WAIT;
            end
            cpu_pkg::S_FETCH_WAIT: begin
                if (cmd_done) begin
                    ctrl.ir_ld = 1'b1;
                    state_n    = cpu_pkg::S_DECODE;
                end
            end
            cpu_pkg::S_DECODE: begin
                case (instr.opcode)
                    cpu_pkg::OP_MOV: begin
                        state_n = instr.c.ind ? cpu_pkg::S_IMM : cpu_pkg::S_RD_B;
                    end
                    cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL: begin
                        state_n = cpu_pkg::S_RD_B;
                    end
                    cpu_pkg::OP_IN:   state_n = wr_entry;
                    cpu_pkg::OP_OUT:  state_n = cpu_pkg::S_RD_A;
                    cpu_pkg::OP_STOP: state_n = cpu_pkg::S_HALT;
                    default:          state_n = cpu_pkg::S_FETCH;   // no-op
                endcase
            end
            cpu_pkg::S_IMM_WAIT: begin
                if (cmd_done) begin
                    ctrl.imm_ld = 1'b1;
                    state_n     = wr_entry;
                end
            end

            // operand a, read only by OUT
            cpu_pkg::S_RD_A: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_FIELD_A;
                state_n       = cpu_pkg::S_RD_A_WAIT;
            end
            cpu_pkg::S_RD_A_WAIT: begin
                if (cmd_done) begin
                    if (instr.a.ind) begin
                        state_n = cpu_pkg::S_RD_A_PTR;
                    end else begin
                        ctrl.opa_ld = 1'b1;
                        state_n     = cpu_pkg::S_OUT;
                    end
                end
            end
            cpu_pkg::S_RD_A_PTR, cpu_pkg::S_RD_B_PTR, cpu_pkg::S_RD_C_PTR: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_POINTER;  // pointer word is still in rd_data
                state_n       = cpu_pkg::state_e'(state + 1'b1);
            end
            cpu_pkg::S_RD_A_PTR_WAIT: begin
                if (cmd_done) begin
                    ctrl.opa_ld = 1'b1;
                    state_n     = cpu_pkg::S_OUT;
                end
            end

            cpu_pkg::S_RD_B: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_FIELD_B;
                state_n       = cpu_pkg::S_RD_B_WAIT;
            end
            cpu_pkg::S_RD_B_WAIT: begin
                if (cmd_done) begin
                    if (instr.b.ind) begin
                        state_n = cpu_pkg::S_RD_B_PTR;
                    end else begin
                        ctrl.opb_ld = 1'b1;
                        state_n     = after_b;
                    end
                end
            end
            cpu_pkg::S_RD_B_PTR_WAIT: begin
                if (cmd_done) begin
                    ctrl.opb_ld = 1'b1;
                    state_n     = after_b;
                end
            end

            cpu_pkg::S_RD_C: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_FIELD_C;
                state_n       = cpu_pkg::S_RD_C_WAIT;
            end
            cpu_pkg::S_RD_C_WAIT: begin
                if (cmd_done) begin
                    if (instr.c.ind) begin
                        state_n = cpu_pkg::S_RD_C_PTR;
                    end else begin
                        ctrl.opc_ld = 1'b1;
                        state_n     = cpu_pkg::S_EXEC;
                    end
                end
            end
            cpu_pkg::S_RD_C_PTR_WAIT: begin
                if (cmd_done) begin
                    ctrl.opc_ld = 1'b1;
                    state_n     = cpu_pkg::S_EXEC;
                end
            end
            cpu_pkg::S_EXEC: begin
                ctrl.res_ld = 1'b1;
                state_n     = wr_entry;
            end

            cpu_pkg::S_WR_A_PTR: begin
                cmd_valid     = 1'b1;
                ctrl.addr_sel = cpu_pkg::AS_FIELD_A;
                state_n       = cpu_pkg::S_WR_A_PTR_WAIT;
            end
            cpu_pkg::S_WR_A_PTR_WAIT: begin
                if (cmd_done) begin
                    state_n = cpu_pkg::S_WR_A;
                end
            end
            cpu_pkg::S_WR_A: begin
                cmd_valid     = 1'b1;
                ctrl.mem_we   = 1'b1;
                ctrl.addr_sel = instr.a.ind ? cpu_pkg::AS_POINTER : cpu_pkg::AS_FIELD_A;
                state_n       = cpu_pkg::S_WR_A_WAIT;
            end
            cpu_pkg::S_WR_A_WAIT: begin
                if (cmd_done) begin
                    state_n = cpu_pkg::S_FETCH;
                end
            end
            cpu_pkg::S_OUT: begin
                ctrl.out_ld = 1'b1;
                state_n     = cpu_pkg::S_FETCH;
            end
            cpu_pkg::S_HALT: begin
                state_n = cpu_pkg::S_HALT;   // no way out except reset
            end
            default: state_n = cpu_pkg::S_INIT;
        endcase
    end

    assign halted = (state == cpu_pkg::S_HALT);

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int ADDR_WIDTH = cpu_pkg::ADDR_W,
    parameter int DATA_WIDTH = cpu_pkg::DATA_W,
    parameter int START_PC   = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    output cpu_pkg::wb_req_t  wb_req,
    input  cpu_pkg::wb_rsp_t  wb_rsp,
    input  cpu_pkg::data_t    in_data,
    output cpu_pkg::data_t    out_data,
    output logic              out_valid,
    output logic              halted
);

    logic              cmd_valid;
    logic              cmd_done;
    cpu_pkg::mem_cmd_t mem_cmd;
    cpu_pkg::data_t    rd_data;
    cpu_pkg::dp_ctrl_t ctrl;
    cpu_pkg::instr_t   instr;

    // memory side, one wishbone transfer per command
    cpu_bus_master #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_bus_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (mem_cmd),
        .cmd_done  (cmd_done),
        .rd_data   (rd_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    cpu_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .cmd_done  (cmd_done),
        .cmd_valid (cmd_valid),
        .ctrl      (ctrl),
        .halted    (halted)
    );

    cpu_datapath #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .START_PC  (START_PC)
    ) u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rd_data   (rd_data),
        .in_data   (in_data),
        .instr     (instr),
        .mem_cmd   (mem_cmd),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

// ==== tests/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::wb_req_t  wb_req,
    output cpu_pkg::wb_rsp_t  wb_rsp
);

    localparam int DEPTH = 2 ** cpu_pkg::ADDR_W;

    cpu_pkg::data_t ram [DEPTH];   // the testbench loads and reads this through the hierarchy
    int             seed = SEED;
    int             delay;         // ack delay of the current transfer, 1 to 4 cycles
    int             waited;
    logic           ack_q;
    cpu_pkg::data_t dat_r_q;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            waited <= 0;
            delay  <= 1 + int'($unsigned($random(seed)) % 4);
        end else begin
            ack_q <= 1'b0;     // ack is a single-cycle pulse
            if (wb_req.cyc && wb_req.stb && !ack_q) begin
                if (waited + 1 >= delay) begin
                    ack_q  <= 1'b1;
                    waited <= 0;
                    delay  <= 1 + int'($unsigned($random(seed)) % 4);
                    if (wb_req.we) begin
                        ram[wb_req.adr] <= wb_req.dat_w;
                    end else begin
                        dat_r_q <= ram[wb_req.adr];
                    end
                end else begin
                    waited <= waited + 1;
                end
            end
        end
    end

    always_comb begin
        wb_rsp.ack   = ack_q;
        wb_rsp.dat_r = dat_r_q;
    end

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int     START_PC         = 8;
    localparam int     NUM_PROGRAMS     = 20;
    localparam int     MAX_WORDS        = 30;
    localparam int     MAX_STEPS        = 40;   // longer model runs get a fresh program
    localparam int     CYCLES_PER_INSTR = 40;
    localparam int     CLK_PERIOD       = 8;
    localparam int     RESET_CYCLES     = 8;
    localparam int     DEPTH            = 2 ** cpu_pkg::ADDR_W;
    localparam longint WATCHDOG_NS      =
        longint'(NUM_PROGRAMS) * MAX_WORDS * CYCLES_PER_INSTR * CLK_PERIOD;

    logic             clk;
    logic             rst_n;
    cpu_pkg::data_t   in_data;
    cpu_pkg::data_t   out_data;
    logic             out_valid;
    logic             halted;
    cpu_pkg::wb_req_t wb_req;
    cpu_pkg::wb_rsp_t wb_rsp;

    int               seed = 32'hece4da86;
    cpu_pkg::data_t   image     [DEPTH];   // initial memory of the current program
    cpu_pkg::data_t   model_mem [DEPTH];
    cpu_pkg::data_t   in_value;
    cpu_pkg::data_t   exp_out [$];
    cpu_pkg::data_t   got_out [$];
    logic             first_adr_pending;
    logic             prev_cyc;
    logic             prev_halted;

    cpu_top #(
        .ADDR_WIDTH(cpu_pkg::ADDR_W),
        .DATA_WIDTH(cpu_pkg::DATA_W),
        .START_PC  (START_PC)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .in_data   (in_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    tb_memory #(.SEED(32'hece4da86)) u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input cpu_pkg::data_t got,
                              input cpu_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                              input cpu_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s got %0d expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    function automatic cpu_pkg::data_t random_word();
        return cpu_pkg::data_t'($random(seed));
    endfunction

    // low bits land in 0-7 or 40-63 and stay clear of the program
    function automatic cpu_pkg::data_t pointer_word();
        cpu_pkg::data_t w;
        int             r;
        w = random_word();
        r = int'($unsigned($random(seed)) % 32);
        w[cpu_pkg::ADDR_W-1:0] = (r < 8) ? cpu_pkg::addr_t'(r) : cpu_pkg::addr_t'(32 + r);
        return w;
    endfunction

    function automatic cpu_pkg::opcode_e pick_opcode();
        int r;
        r = int'($unsigned($random(seed)) % 12);
        case (r)
            0, 1:    return cpu_pkg::OP_MOV;
            2, 8:    return cpu_pkg::OP_ADD;
            3:       return cpu_pkg::OP_SUB;
            4, 9:    return cpu_pkg::OP_MUL;
            5:       return cpu_pkg::OP_IN;
            6, 7:    return cpu_pkg::OP_OUT;
            default: begin
                r = int'($unsigned($random(seed)) % 9);   // no-op codes 4-6 and 9-14
                return cpu_pkg::opcode_e'((r < 3) ? 4 + r : 6 + r);
            end
        endcase
    endfunction

    function automatic cpu_pkg::operand_t random_operand(input bit use_ind);
        cpu_pkg::operand_t op;
        op.ind  = use_ind && ($random(seed) % 2 != 0);
        op.addr = cpu_pkg::field_addr_t'($random(seed));
        return op;
    endfunction

    function automatic cpu_pkg::addr_t operand_addr(input cpu_pkg::operand_t op);
        if (op.ind) begin
            return model_mem[op.addr][cpu_pkg::ADDR_W-1:0];
        end else begin
            return cpu_pkg::addr_t'(op.addr);
        end
    endfunction

    task automatic generate_image(input bit use_ind);
        int              pc;
        int              body;
        cpu_pkg::instr_t ins;
        for (int i = 0; i < DEPTH; i++) image[i] = random_word();
        for (int i = 0; i < 8; i++) image[i] = pointer_word();  // any low word may be a pointer
        in_value = random_word();
        body     = int'($unsigned($random(seed)) % (MAX_WORDS - 1));
        pc       = START_PC;
        while (pc < START_PC + body) begin
            ins.opcode = pick_opcode();
            ins.a      = random_operand(use_ind);
            ins.b      = random_operand(use_ind);
            ins.c      = random_operand(use_ind);
            if (ins.opcode == cpu_pkg::OP_MOV) ins.c.ind = ($random(seed) % 2 != 0);
            image[pc] = cpu_pkg::data_t'(ins);
            pc++;
            if (ins.opcode == cpu_pkg::OP_MOV && ins.c.ind) begin
                image[pc] = random_word();   // immediate word
                pc++;
            end
        end
        ins.opcode = cpu_pkg::OP_STOP;
        image[pc]  = cpu_pkg::data_t'(ins);
    endtask

    task automatic run_model(output bit ok);
        cpu_pkg::addr_t  pc;
        cpu_pkg::instr_t ins;
        cpu_pkg::data_t  value;
        int              steps;
        bit              write_a;
        model_mem = image;
        exp_out.delete();
        pc    = cpu_pkg::addr_t'(START_PC);
        steps = 0;
        ok    = 1'b0;
        while (!ok && steps < MAX_STEPS) begin
            ins = cpu_pkg::instr_t'(model_mem[pc]);
            pc++;
            steps++;
            write_a = 1'b1;
            case (ins.opcode)
                cpu_pkg::OP_MOV: begin
                    if (ins.c.ind) begin
                        value = model_mem[pc];
                        pc++;
                    end else begin
                        value = model_mem[operand_addr(ins.b)];
                    end
                end
                cpu_pkg::OP_ADD: begin
                    value = model_mem[operand_addr(ins.b)] + model_mem[operand_addr(ins.c)];
                end
                cpu_pkg::OP_SUB: begin
                    value = model_mem[operand_addr(ins.b)] - model_mem[operand_addr(ins.c)];
                end
                cpu_pkg::OP_MUL: begin
                    value = model_mem[operand_addr(ins.b)] * model_mem[operand_addr(ins.c)];
                end
                cpu_pkg::OP_IN:  value = in_value;
                cpu_pkg::OP_OUT: begin
                    exp_out.push_back(model_mem[operand_addr(ins.a)]);
                    write_a = 1'b0;
                end
                cpu_pkg::OP_STOP: begin
                    ok      = 1'b1;
                    write_a = 1'b0;
                end
                default: write_a = 1'b0;   // no-op
            endcase
            if (write_a) model_mem[operand_addr(ins.a)] = value;
        end
    endtask

    task automatic check_idle();
        check_bit("wb_req.cyc", wb_req.cyc, 1'b0);
        check_bit("wb_req.stb", wb_req.stb, 1'b0);
        check_bit("wb_req.we", wb_req.we, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_data("out_data", out_data, '0);
    endtask

    task automatic run_program();
        @(posedge clk);
        #1;
        rst_n   = 1'b0;
        in_data = in_value;
        for (int i = 0; i < DEPTH; i++) u_mem.ram[i] = image[i];
        got_out.delete();
        first_adr_pending = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_idle();                 // first cycle out of reset
        while (halted !== 1'b1) @(negedge clk);
        repeat (4) @(negedge clk);    // the monitor catches any bus cycle after the halt
    endtask

    task automatic compare_results(input int prog);
        for (int i = 0; i < DEPTH; i++) begin
            check_data($sformatf("mem[%0d]", i), u_mem.ram[i], model_mem[i]);
        end
        if (got_out.size() != exp_out.size()) begin
            stop_with_failure($sformatf("program %0d gave %0d OUT values, %0d expected",
                                        prog, got_out.size(), exp_out.size()));
        end
        foreach (exp_out[i]) check_data($sformatf("out_data #%0d", i), got_out[i], exp_out[i]);
    endtask

    // bus and output monitor samples on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) got_out.push_back(out_data);
            if (wb_req.cyc && !prev_cyc && first_adr_pending) begin
                check_addr("wb_req.adr", wb_req.adr, cpu_pkg::addr_t'(START_PC));
                first_adr_pending = 1'b0;
            end
            if (halted && wb_req.cyc) stop_with_failure("a bus cycle ran after the CPU halted");
            if (prev_halted && !halted) stop_with_failure("halted dropped without a reset");
            prev_cyc    = wb_req.cyc;
            prev_halted = halted;
        end else begin
            prev_cyc    = 1'b0;
            prev_halted = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired, the CPU never halted");
    end

    initial begin
        bit ok;
        rst_n             = 1'b0;
        in_data           = '0;
        first_adr_pending = 1'b0;
        prev_cyc          = 1'b0;
        prev_halted       = 1'b0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            ok = 1'b0;
            while (!ok) begin
                generate_image(p >= 4);   // first programs use direct operands only
                run_model(ok);
            end
            run_program();
            compare_results(p);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
SOURCES   := $(wildcard hdl/*.sv tests/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
hdl/cpu_pkg.sv
hdl/cpu_bus_master.sv
hdl/cpu_datapath.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
tests/tb_memory.sv
tests/cpu_tb.sv
